//--- Makefile
# Verilator build and run for the AXI-stream fan-in testbench

VERILATOR ?= verilator
TOP       ?= axis_fan_in_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

# the run passes only when the pass line shows up in the output
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
design/axis_fan_in_pkg.sv
design/prio_encoder.sv
design/axis_fan_in.sv
design/axis_fifo_sync.sv
design/axis_fan_in_top.sv
tb/tb_clock_gen.sv
tb/axis_fan_in_tb.sv

//--- design/axis_fan_in.sv
// packet-locking arbiter and mux, merges the input channels into one tagged beat stream
`timescale 1ns/1ps

module axis_fan_in
  import axis_fan_in_pkg::*;
(
  input  logic                             s_axis_clk,
  input  logic                             reset,

  // input channels
  input  logic [CHAN_COUNT-1:0]            s_axis_tvalid,
  output logic [CHAN_COUNT-1:0]            s_axis_tready,
  input  logic [CHAN_COUNT-1:0][DATA_W-1:0] s_axis_tdata,
  input  logic [CHAN_COUNT-1:0]            s_axis_tlast,

  // merged stream toward the buffer
  output logic                             fanin_valid,
  input  logic                             fanin_ready,
  output beat_t                            fanin_beat
);

  //////////////////////////////
  // internal signals
  //////////////////////////////

  arb_state_t        state;
  logic [CHAN_W-1:0] held_chan;

  // encoder result
  logic [CHAN_W-1:0] pick_chan;
  logic              pick_any;

  // channel currently driving the output
  logic [CHAN_W-1:0] sel_chan;
  logic              granted;
  logic              beat_fire;

  //////////////////////////////
  // channel selection
  //////////////////////////////

  prio_encoder u_prio_encoder (
    .valid (s_axis_tvalid),
    .index (pick_chan),
    .any   (pick_any)
  );

  // locked channel keeps the grant
  // otherwise follow the encoder in the same cycle
  assign sel_chan = (state == ARB_LOCKED) ? held_chan : pick_chan;

  // a grant exists while locked, or when any channel asks while idle
  assign granted = (state == ARB_LOCKED) || pick_any;

  //////////////////////////////
  // datapath
  //////////////////////////////

  assign fanin_valid     = s_axis_tvalid[sel_chan];
  assign fanin_beat.last = s_axis_tlast[sel_chan];
  assign fanin_beat.data = s_axis_tdata[sel_chan];
  assign fanin_beat.user = sel_chan;

  assign beat_fire = fanin_valid && fanin_ready;

  // ready goes back to the granted channel only
  always_comb begin
    s_axis_tready = '0;
    if (granted) begin
      s_axis_tready[sel_chan] = fanin_ready;
    end
  end

  //////////////////////////////
  // arbiter FSM
  //////////////////////////////

  // first beat without last locks the channel
  // a single-beat packet never leaves idle
  always_ff @(posedge s_axis_clk) begin
    if (reset) begin
      state     <= ARB_IDLE;
      held_chan <= '0;
    end else begin
      case (state)
        ARB_IDLE: begin
          if (beat_fire && !fanin_beat.last) begin
            state     <= ARB_LOCKED;
            held_chan <= sel_chan;
          end
        end
        ARB_LOCKED: begin
          // release once the last beat is taken
          if (beat_fire && fanin_beat.last) begin
            state <= ARB_IDLE;
          end
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  // never hand ready to two channels at once
  assert property (@(posedge s_axis_clk) disable iff (reset)
    $onehot0(s_axis_tready))
    else $error("axis_fan_in ready on several channels %b", s_axis_tready);

  // held channel frozen for the whole packet
  assert property (@(posedge s_axis_clk) disable iff (reset)
    (state == ARB_LOCKED) |=> (state == ARB_IDLE) || $stable(held_chan))
    else $error("axis_fan_in held channel moved mid packet");

endmodule

//--- design/axis_fan_in_pkg.sv
// shared widths, beat struct and arbiter state type, imported by the fan-in design modules
package axis_fan_in_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  // number of competing input channels
  localparam int CHAN_COUNT = 4;

  // bits needed for a channel index
  localparam int CHAN_W = 2;

  // payload word width
  localparam int DATA_W = 32;

  //////////////////////////////
  // types
  //////////////////////////////

  // one beat on the merged stream
  // user carries the source channel, last marks end of packet
  typedef struct packed {
    logic              last;
    logic [DATA_W-1:0] data;
    logic [CHAN_W-1:0] user;
  } beat_t;

  // arbiter state
  // idle picks a new channel each cycle, locked holds one until tlast
  typedef enum logic {
    ARB_IDLE   = 1'b0,
    ARB_LOCKED = 1'b1
  } arb_state_t;

endpackage

//--- design/axis_fan_in_top.sv
// fan-in subsystem top, arbiter feeding the output FIFO, instantiated by the testbench as DUT
`timescale 1ns/1ps

module axis_fan_in_top
  import axis_fan_in_pkg::*;
#(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                              s_axis_clk,
  input  logic                              reset,

  // input channels
  input  logic [CHAN_COUNT-1:0]             s_axis_tvalid,
  output logic [CHAN_COUNT-1:0]             s_axis_tready,
  input  logic [CHAN_COUNT-1:0][DATA_W-1:0] s_axis_tdata,
  input  logic [CHAN_COUNT-1:0]             s_axis_tlast,

  // merged output stream
  output logic                              m_axis_tvalid,
  input  logic                              m_axis_tready,
  output beat_t                             m_axis_tbeat
);

  //////////////////////////////
  // arbiter to FIFO
  //////////////////////////////

  logic  fanin_valid;
  logic  fanin_ready;
  beat_t fanin_beat;

  axis_fan_in u_axis_fan_in (
    .s_axis_clk    (s_axis_clk),
    .reset         (reset),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tlast  (s_axis_tlast),
    .fanin_valid   (fanin_valid),
    .fanin_ready   (fanin_ready),
    .fanin_beat    (fanin_beat)
  );

  // output buffer
  // takes back-pressure off the arbiter
  axis_fifo_sync #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_axis_fifo_sync (
    .s_axis_clk (s_axis_clk),
    .reset      (reset),
    .in_valid   (fanin_valid),
    .in_ready   (fanin_ready),
    .in_beat    (fanin_beat),
    .out_valid  (m_axis_tvalid),
    .out_ready  (m_axis_tready),
    .out_beat   (m_axis_tbeat)
  );

endmodule

//--- design/axis_fifo_sync.sv
// synchronous first-word-fall-through beat FIFO with a registered output stage
`timescale 1ns/1ps

module axis_fifo_sync
  import axis_fan_in_pkg::*;
#(
  parameter int FIFO_DEPTH = 8
) (
  input  logic  s_axis_clk,
  input  logic  reset,

  // write side
  input  logic  in_valid,
  output logic  in_ready,
  input  beat_t in_beat,

  // read side
  output logic  out_valid,
  input  logic  out_ready,
  output beat_t out_beat
);

  localparam int ADDR_W = $clog2(FIFO_DEPTH);

  //////////////////////////////
  // storage and pointers
  //////////////////////////////

  beat_t             mem [FIFO_DEPTH];
  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] rd_ptr;

  // entries held in mem, output register not counted
  logic [ADDR_W:0]   count;

  logic              in_fire;
  logic              load_out;
  logic              bypass;
  logic              mem_wr;
  logic              mem_rd;

  //////////////////////////////
  // control
  //////////////////////////////

  assign in_ready = (count != ADDR_W'(0) + (ADDR_W + 1)'(FIFO_DEPTH));
  assign in_fire  = in_valid && in_ready;

  // output stage empty or draining this cycle
  assign load_out = !out_valid || out_ready;

  // empty memory, so a new beat goes straight to the output
  assign bypass = load_out && (count == '0) && in_fire;

  assign mem_rd = load_out && (count != '0);
  assign mem_wr = in_fire && !bypass;

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge s_axis_clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (mem_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (mem_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + (ADDR_W + 1)'(mem_wr) - (ADDR_W + 1)'(mem_rd);
    end
  end

  //////////////////////////////
  // datapath
  //////////////////////////////

  always_ff @(posedge s_axis_clk) begin
    if (mem_wr) begin
      mem[wr_ptr] <= in_beat;
    end
  end

  // oldest stored beat first, then the bypass path
  always_ff @(posedge s_axis_clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (load_out) begin
      out_valid <= mem_rd || bypass;
    end
  end

  always_ff @(posedge s_axis_clk) begin
    if (mem_rd) begin
      out_beat <= mem[rd_ptr];
    end else if (bypass) begin
      out_beat <= in_beat;
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  assert property (@(posedge s_axis_clk) disable iff (reset)
    mem_wr |-> (count < (ADDR_W + 1)'(FIFO_DEPTH)))
    else $error("axis_fifo_sync write while full");

  // stalled output must hold its beat
  assert property (@(posedge s_axis_clk) disable iff (reset)
    (out_valid && !out_ready) |=> out_valid && $stable(out_beat))
    else $error("axis_fifo_sync output changed under back-pressure");

endmodule

//--- design/prio_encoder.sv
// combinational priority encoder, returns the highest set valid bit and an any-valid flag
`timescale 1ns/1ps

module prio_encoder
  import axis_fan_in_pkg::*;
(
  input  logic [CHAN_COUNT-1:0] valid,
  output logic [CHAN_W-1:0]     index,
  output logic                  any
);

  //////////////////////////////
  // encoder
  //////////////////////////////

  // walk from the top channel down
  // first set bit found wins, so MSB channels take priority
  always_comb begin
    index = '0;
    any   = 1'b0;
    for (int i = CHAN_COUNT - 1; i >= 0; i--) begin
      if (valid[i] && !any) begin
        index = CHAN_W'(i);
        any   = 1'b1;
      end
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  // picked bit must be set, and nothing above it
  // shifting down by index should leave exactly 1
  always_comb begin
    if (any) begin
      assert ((valid >> index) == CHAN_COUNT'(1))
        else $error("prio_encoder picked %0d for valid %b", index, valid);
    end else begin
      assert (valid == '0)
        else $error("prio_encoder missed valid %b", valid);
    end
  end

endmodule

//--- tb/axis_fan_in_tb.sv
// testbench for the fan-in top that plays a packet table and checks every output beat per channel
`timescale 1ns/1ps

module axis_fan_in_tb
  import axis_fan_in_pkg::*;
();

  localparam int FIFO_DEPTH    = 4;
  localparam int PKT_COUNT     = 17;
  localparam int SAMPLE_DELAY  = 10;
  localparam int RESET_TIMEOUT = 20;
  localparam int IDLE_CYCLES   = 3;

  //////////////////////////////
  // DUT signals
  //////////////////////////////

  logic                             s_axis_clk;
  logic                             reset;
  logic [CHAN_COUNT-1:0]            s_axis_tvalid;
  logic [CHAN_COUNT-1:0]            s_axis_tready;
  logic [CHAN_COUNT-1:0][DATA_W-1:0] s_axis_tdata;
  logic [CHAN_COUNT-1:0]            s_axis_tlast;
  logic                             m_axis_tvalid;
  logic                             m_axis_tready;
  beat_t                            m_axis_tbeat;

  //////////////////////////////
  // stimulus table
  //////////////////////////////

  // one packet as phase, channel, beat count and the step it is offered
  typedef struct packed {
    int phase;
    int chan;
    int len;
    int start;
  } pkt_entry_t;

  pkt_entry_t pkt_table [PKT_COUNT] = '{
    // single channel
    '{2, 1, 4, 0},
    // priority with both offered at once
    '{3, 0, 3, 0}, '{3, 3, 3, 0},
    // packet lock with channel 3 showing up mid packet
    '{4, 0, 5, 0}, '{4, 3, 3, 2},
    // back-pressure with every channel sending several times
    '{5, 0, 3, 0}, '{5, 1, 2, 0}, '{5, 2, 4, 1}, '{5, 3, 1, 1},
    '{5, 0, 1, 6}, '{5, 1, 5, 3}, '{5, 2, 2, 8}, '{5, 3, 4, 5},
    '{5, 0, 4, 12}, '{5, 1, 1, 14}, '{5, 2, 3, 10}, '{5, 3, 2, 15}
  };

  // beats waiting at each source with the head on the bus
  beat_t send_q [CHAN_COUNT][$];
  // beats still owed by the DUT per source channel
  beat_t exp_q [CHAN_COUNT][$];
  // source channel of every output beat in this phase
  logic [CHAN_W-1:0] out_order [$];

  int                    seq_cnt [CHAN_COUNT];
  logic [CHAN_COUNT-1:0] in_fire;
  logic                  out_in_packet;
  logic [CHAN_W-1:0]     out_chan;
  logic                  random_ready;

  tb_clock_gen #(
    .PERIOD_NS    (100),
    .RESET_CYCLES (4)
  ) u_tb_clock_gen (
    .s_axis_clk (s_axis_clk),
    .reset      (reset)
  );

  axis_fan_in_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) DUT (
    .s_axis_clk    (s_axis_clk),
    .reset         (reset),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tlast  (s_axis_tlast),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tbeat  (m_axis_tbeat)
  );

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task automatic stop_on_error(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1, "first error reached");
  endtask

  task automatic check_beat(input string name, input beat_t expected, input beat_t actual);
    if (actual !== expected) begin
      stop_on_error($sformatf(
        "Mismatch in %s: expected last=%0b data=%h user=%0d, actual last=%0b data=%h user=%0d",
        name, expected.last, expected.data, expected.user,
        actual.last, actual.data, actual.user));
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("Mismatch in %s: expected %b, actual %b",
                              name, expected, actual));
    end
  endtask

  task automatic check_chan(input string name, input logic [CHAN_W-1:0] expected,
                            input logic [CHAN_W-1:0] actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("Mismatch in %s: expected channel %0d, actual channel %0d",
                              name, expected, actual));
    end
  endtask

  //////////////////////////////
  // table helpers
  //////////////////////////////

  function automatic int last_start(input int phase);
    int latest;
    latest = 0;
    foreach (pkt_table[i]) begin
      if (pkt_table[i].phase == phase && pkt_table[i].start > latest) begin
        latest = pkt_table[i].start;
      end
    end
    return latest;
  endfunction

  // total beats a channel offers in one phase
  function automatic int packet_beats(input int phase, input int chan);
    int total;
    total = 0;
    foreach (pkt_table[i]) begin
      if (pkt_table[i].phase == phase && pkt_table[i].chan == chan) begin
        total += pkt_table[i].len;
      end
    end
    return total;
  endfunction

  function automatic bit sources_idle();
    bit idle;
    idle = 1'b1;
    for (int ch = 0; ch < CHAN_COUNT; ch++) begin
      if (send_q[ch].size() != 0 || exp_q[ch].size() != 0) begin
        idle = 1'b0;
      end
    end
    return idle;
  endfunction

  // data word is channel number then running count
  task automatic queue_packet(input int chan, input int len);
    beat_t beat;
    for (int i = 0; i < len; i++) begin
      beat.last = (i == len - 1);
      beat.data = {8'(chan), 24'(seq_cnt[chan])};
      beat.user = CHAN_W'(chan);
      send_q[chan].push_back(beat);
      exp_q[chan].push_back(beat);
      seq_cnt[chan]++;
    end
  endtask

  //////////////////////////////
  // cycle driver and monitor
  //////////////////////////////

  task automatic drive_inputs();
    for (int ch = 0; ch < CHAN_COUNT; ch++) begin
      if (send_q[ch].size() != 0) begin
        s_axis_tvalid[ch] = 1'b1;
        s_axis_tdata[ch]  = send_q[ch][0].data;
        s_axis_tlast[ch]  = send_q[ch][0].last;
      end else begin
        s_axis_tvalid[ch] = 1'b0;
        s_axis_tdata[ch]  = '0;
        s_axis_tlast[ch]  = 1'b0;
      end
    end
  endtask

  // output beat about to transfer on the next rising edge
  task automatic take_output(input string name);
    beat_t act;
    int    u;
    act = m_axis_tbeat;
    u   = int'(act.user);
    if (out_in_packet && act.user != out_chan) begin
      stop_on_error($sformatf("%s: beat of channel %0d cut into a packet of channel %0d",
                              name, act.user, out_chan));
    end
    if (exp_q[u].size() == 0) begin
      stop_on_error($sformatf("%s: output beat from channel %0d that never sent one",
                              name, u));
    end
    check_beat(name, exp_q[u][0], act);
    void'(exp_q[u].pop_front());
    out_order.push_back(act.user);
    out_in_packet = !act.last;
    out_chan      = act.user;
  endtask

  // drive on the falling edge and sample well before the next rising edge
  task automatic advance_cycle(input string name, input int phase, input int step);
    @(negedge s_axis_clk);
    for (int ch = 0; ch < CHAN_COUNT; ch++) begin
      if (in_fire[ch]) begin
        void'(send_q[ch].pop_front());
      end
    end
    foreach (pkt_table[i]) begin
      if (pkt_table[i].phase == phase && pkt_table[i].start == step) begin
        queue_packet(pkt_table[i].chan, pkt_table[i].len);
      end
    end
    drive_inputs();
    m_axis_tready = random_ready ? 1'($urandom) : 1'b1;
    #SAMPLE_DELAY;
    for (int ch = 0; ch < CHAN_COUNT; ch++) begin
      in_fire[ch] = s_axis_tvalid[ch] && s_axis_tready[ch];
    end
    if (m_axis_tvalid && m_axis_tready) begin
      take_output(name);
    end
  endtask

  //////////////////////////////
  // phase control
  //////////////////////////////

  task automatic await_reset();
    int cycles;
    cycles = 0;
    while (reset) begin
      if (cycles >= RESET_TIMEOUT) begin
        stop_on_error("reset was never released");
      end
      @(negedge s_axis_clk);
      #SAMPLE_DELAY;
      cycles++;
    end
  endtask

  // run until all packets of the phase are offered and drained
  task automatic play_phase(input string name, input int phase, input int max_cycles);
    int step;
    bit done;
    step = 0;
    done = 1'b0;
    out_order.delete();
    while (!done) begin
      if (step >= max_cycles) begin
        stop_on_error($sformatf("%s: packets still pending after %0d cycles",
                                name, max_cycles));
      end
      advance_cycle(name, phase, step);
      step++;
      done = (step > last_start(phase)) && sources_idle();
    end
    // quiet tail where any stray beat fails in take_output
    for (int i = 0; i < IDLE_CYCLES; i++) begin
      advance_cycle(name, 0, i);
    end
    check_bit({name, " output idle"}, 1'b0, m_axis_tvalid);
  endtask

  // whole packet of the first channel before the second
  task automatic verify_order(input string name, input int phase,
                              input int first_chan, input int second_chan);
    int                first_len;
    int                total;
    logic [CHAN_W-1:0] exp_chan;
    first_len = packet_beats(phase, first_chan);
    total     = first_len + packet_beats(phase, second_chan);
    check_bit({name, " beat count"}, 1'b1, out_order.size() == total);
    for (int i = 0; i < total; i++) begin
      exp_chan = (i < first_len) ? CHAN_W'(first_chan) : CHAN_W'(second_chan);
      check_chan($sformatf("%s beat %0d", name, i), exp_chan, out_order[i]);
    end
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    s_axis_tvalid = '0;
    s_axis_tdata  = '0;
    s_axis_tlast  = '0;
    m_axis_tready = 1'b0;
    in_fire       = '0;
    out_in_packet = 1'b0;
    out_chan      = '0;
    random_ready  = 1'b0;
    foreach (seq_cnt[ch]) begin
      seq_cnt[ch] = 0;
    end
    void'($urandom(32'h7c56));

    await_reset();

    // nothing valid after reset so nothing ready
    for (int i = 0; i < IDLE_CYCLES; i++) begin
      advance_cycle("after reset", 0, i);
      check_bit("after reset m_axis_tvalid", 1'b0, m_axis_tvalid);
      for (int ch = 0; ch < CHAN_COUNT; ch++) begin
        check_bit($sformatf("after reset s_axis_tready[%0d]", ch), 1'b0, s_axis_tready[ch]);
      end
    end

    // user tag and last come from the expected beats
    play_phase("single channel", 2, 100);
    check_bit("single channel beat count", 1'b1, out_order.size() == packet_beats(2, 1));

    play_phase("priority", 3, 100);
    verify_order("priority", 3, 3, 0);

    play_phase("packet lock", 4, 100);
    verify_order("packet lock", 4, 0, 3);

    // downstream stalls at random
    random_ready = 1'b1;
    play_phase("back-pressure", 5, 1000);
    random_ready = 1'b0;

    $display("Testbench passed");
    $finish;
  end

endmodule

//--- tb/tb_clock_gen.sv
// clock and power-on reset source for the fan-in testbench, instantiated once by its top module
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 4
) (
  output logic s_axis_clk,
  output logic reset
);

  // free-running clock, starts low
  initial begin
    s_axis_clk = 1'b0;
    forever #(PERIOD_NS / 2) s_axis_clk = ~s_axis_clk;
  end

  // reset covers the first rising edges
  // released on a falling edge like every other input
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge s_axis_clk);
    @(negedge s_axis_clk);
    reset = 1'b0;
  end

endmodule
